// ==== Makefile ====
# Verilator build and run of the crc24 testbench

LOG = sim.log

.PHONY: sim clean

# pass only when the log holds the pass line
sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module tb_ilk_crc -o Vtb_ilk_crc
	./obj_dir/Vtb_ilk_crc | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== source/beat_pair_gather.sv ====
`timescale 1ns/10ps
`default_nettype none

// parks the first word of a pair and issues registered beats
module beat_pair_gather import ilk_crc_pkg::*; (
	input  logic    clk,
	input  logic    arst,
	input  word64_t word,
	input  logic    hold,
	input  logic    emit,
	input  cover_t  beat_cover,
	output logic    beat_valid,
	output cover_t  beat_cover_q,
	output crc24_t  evo_dat_0,
	output crc24_t  evo_dat_n1
);

	word64_t held_word;
	crc24_t  evo_held;
	crc24_t  evo_new;

	// one fold per word in the pair
	crc24_word_fold fold_held_i (.word(held_word), .evo(evo_held));
	crc24_word_fold fold_new_i (.word(word), .evo(evo_new));

	always_ff @(posedge clk) begin
		if (hold)
			held_word <= word;
		// beat payload, only meaningful with beat_valid
		if (emit) begin
			evo_dat_0    <= evo_new;
			evo_dat_n1   <= evo_held;
			beat_cover_q <= beat_cover;
		end
	end

	// one cycle from emit to beat_valid
	always_ff @(posedge clk or posedge arst) begin
		if (arst)
			beat_valid <= 1'b0;
		else
			beat_valid <= emit;
	end

	// a word is either parked or issued, never both
	a_hold_emit_excl: assert property (@(posedge clk) disable iff (arst)
		!(hold && emit));

endmodule

`default_nettype wire

// ==== source/burst_word_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

// words left in the burst, plus the drain timer after the last one
module burst_word_counter import ilk_crc_pkg::*; (
	input  logic       clk,
	input  logic       arst,
	input  logic       load,
	input  logic       dec,
	input  burst_len_t len_val,
	output burst_len_t remaining,
	output logic       drain_end
);

	// zero when idle, then counts 1..3 after the last word
	logic [1:0] drain_cnt;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			remaining <= '0;
			drain_cnt <= 2'd0;
		end else begin
			if (load)
				remaining <= len_val;
			else if (dec)
				remaining <= remaining - 1'b1;
			// timer kicks off as the count hits zero
			if (load)
				drain_cnt <= 2'd0;
			else if (dec && remaining == burst_len_t'(1))
				drain_cnt <= 2'd1;
			else if (drain_cnt != 2'd0)
				drain_cnt <= drain_cnt + 2'd1;
		end
	end

	// three cycles covers gather plus both combiner stages
	assign drain_end = (drain_cnt == 2'd3);

	// controller stops taking words once the count is spent
	a_no_underflow: assert property (@(posedge clk) disable iff (arst)
		dec |-> remaining != '0);

endmodule

`default_nettype wire

// ==== source/crc24_multi_combine.sv ====
`timescale 1ns/10ps
`default_nettype none

// merges one beat of evolved words into the running crc
// two stage pipe, rolling crc picked up in stage two so beats can stream
module crc24_multi_combine import ilk_crc_pkg::*; (
	input  logic   clk,
	input  logic   arst,
	input  logic   valid,
	input  cover_t covered,
	input  crc24_t evo_dat_0,
	input  crc24_t evo_dat_n1,
	output crc24_t crc_out
);

	//////////////////////////////
	// all ones seed moved forward by one and two words
	// constant once synthesized
	crc24_t evo_ones;
	crc24_t evox2_ones;

	crc24_zero_advance #(.STEPS(1)) ones_x1_i (.crc_in('1), .crc_out(evo_ones));
	crc24_zero_advance #(.STEPS(2)) ones_x2_i (.crc_in('1), .crc_out(evox2_ones));

	//////////////////////////////
	// older word of a pair sits one word before the newest
	crc24_t evox1_dat_n1;
	// rolling crc moved past both words of a pair
	crc24_t evox2_crc;

	crc24_zero_advance #(.STEPS(1)) dat_n1_x1_i (.crc_in(evo_dat_n1), .crc_out(evox1_dat_n1));
	crc24_zero_advance #(.STEPS(2)) crc_x2_i (.crc_in(crc_out), .crc_out(evox2_crc));

	//////////////////////////////
	// stage one
	logic   last_valid;
	cover_t last_covered;
	crc24_t evo_dat_0_r;
	crc24_t term_n1_r;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			last_valid   <= 1'b0;
			last_covered <= 2'd0;
		end else begin
			last_valid   <= valid;
			last_covered <= covered;
		end
	end

	always_ff @(posedge clk) begin
		// newest word always counts, no shift needed
		evo_dat_0_r <= evo_dat_0;
		// n1 only counts when the beat is a pair
		term_n1_r   <= (covered == 2'd1 || covered == 2'd2) ? evox1_dat_n1 : '0;
	end

	//////////////////////////////
	// stage two, pick the head term
	crc24_t term_head;

	always_comb begin
		case (last_covered)
			2'd0:    term_head = evo_ones;
			2'd1:    term_head = evox2_ones;
			// mid burst, read crc_out late so the previous beat has landed
			2'd2:    term_head = evox2_crc;
			default: term_head = '0;
		endcase
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst)
			crc_out <= '1;
		else if (last_valid)
			crc_out <= evo_dat_0_r ^ term_n1_r ^ term_head;
	end

	// gather must never hand over the unused cover code
	a_cover_legal: assert property (@(posedge clk) disable iff (arst)
		valid |-> covered != 2'd3);

	// upstream beat register comes out of reset quiet
	a_quiet_after_reset: assert property (@(posedge clk) $fell(arst) |-> !valid);

endmodule

`default_nettype wire

// ==== source/crc24_word_fold.sv ====
`include "ilk_crc_cfg.svh"
`timescale 1ns/10ps
`default_nettype none

// crc24 of a single 64 bit word from a zero seed
// later stages move this term forward by its position in the burst
module crc24_word_fold import ilk_crc_pkg::*; (
	input  word64_t word,
	output crc24_t  evo
);

	always_comb begin
		crc24_t c;
		logic   fb;
		c = '0;
		// msb of the word goes in first
		for (int i = `WORD_W - 1; i >= 0; i--) begin
			fb = c[`CRC_W-1] ^ word[i];
			c = {c[`CRC_W-2:0], 1'b0};
			if (fb)
				c = c ^ `CRC_POLY;
		end
		evo = c;
	end

endmodule

`default_nettype wire

// ==== source/crc24_zero_advance.sv ====
`include "ilk_crc_cfg.svh"
`timescale 1ns/10ps
`default_nettype none

// pushes a crc24 state through STEPS words of zero data
// used both for the constant all ones evolutions and for data terms
module crc24_zero_advance import ilk_crc_pkg::*; #(
	parameter int STEPS = 1
) (
	input  crc24_t crc_in,
	output crc24_t crc_out
);

	always_comb begin
		crc24_t c;
		c = crc_in;
		// zero data bit, so feedback comes from the msb alone
		for (int i = 0; i < STEPS * `WORD_W; i++) begin
			if (c[`CRC_W-1])
				c = {c[`CRC_W-2:0], 1'b0} ^ `CRC_POLY;
			else
				c = {c[`CRC_W-2:0], 1'b0};
		end
		// unrolls into a flat xor network
		crc_out = c;
	end

endmodule

`default_nettype wire

// ==== source/crc_burst_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

// burst controller, decides per word whether to park or issue a beat
module crc_burst_fsm import ilk_crc_pkg::*; (
	input  logic       clk,
	input  logic       arst,
	input  logic       len_we,
	input  logic       word_we,
	input  burst_len_t len_val,
	input  burst_len_t remaining,
	input  logic       drain_end,
	output logic       load,
	output logic       dec,
	output logic       hold,
	output logic       emit,
	output cover_t     beat_cover,
	output logic       busy,
	output logic       burst_done
);

	burst_state_t state;
	burst_state_t state_nx;
	// high while a parked word waits for its partner
	logic         phase;
	logic         phase_nx;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			state <= st_idle;
			phase <= 1'b0;
		end else begin
			state <= state_nx;
			phase <= phase_nx;
		end
	end

	always_comb begin
		state_nx   = state;
		phase_nx   = phase;
		load       = 1'b0;
		dec        = 1'b0;
		hold       = 1'b0;
		emit       = 1'b0;
		beat_cover = 2'd0;
		burst_done = 1'b0;
		case (state)
			st_idle: begin
				// zero length never starts a burst
				if (len_we && len_val != '0) begin
					load     = 1'b1;
					phase_nx = 1'b0;
					state_nx = st_first;
				end
			end
			st_first: begin
				if (word_we) begin
					dec = 1'b1;
					if (phase) begin
						// second word of an even burst
						emit       = 1'b1;
						beat_cover = 2'd1;
						phase_nx   = 1'b0;
						state_nx   = (remaining == burst_len_t'(1)) ? st_drain : st_pairs;
					end else if (remaining[0]) begin
						// odd burst, first word goes out alone
						emit       = 1'b1;
						beat_cover = 2'd0;
						state_nx   = (remaining == burst_len_t'(1)) ? st_drain : st_pairs;
					end else begin
						hold     = 1'b1;
						phase_nx = 1'b1;
					end
				end
			end
			st_pairs: begin
				if (word_we) begin
					dec = 1'b1;
					if (!phase) begin
						hold     = 1'b1;
						phase_nx = 1'b1;
					end else begin
						emit       = 1'b1;
						beat_cover = 2'd2;
						phase_nx   = 1'b0;
					end
					// pairs always end on an issued word
					if (remaining == burst_len_t'(1))
						state_nx = st_drain;
				end
			end
			st_drain: begin
				// extra words land here and are dropped
				if (drain_end) begin
					burst_done = 1'b1;
					state_nx   = st_idle;
				end
			end
			default: state_nx = st_idle;
		endcase
	end

	assign busy = (state != st_idle);

endmodule

`default_nettype wire

// ==== source/ilk_crc_cfg.svh ====
`ifndef ILK_CRC_CFG_SVH
`define ILK_CRC_CFG_SVH

// interlaken crc24 generator, x^24 term implicit
`define CRC_POLY 24'h328b63

// crc state and data word widths
`define CRC_W 24
`define WORD_W 64

// burst length field and its largest legal value
`define LEN_W 8
`define MAX_LEN 255

// wishbone register map, word addressed
`define REG_DATA 2'd0
`define REG_LEN 2'd1
`define REG_STATUS 2'd2
`define REG_RESULT 2'd3

`endif

// ==== source/ilk_crc_pkg.sv ====
`include "ilk_crc_cfg.svh"
`default_nettype none

package ilk_crc_pkg;

	// crc state, also used for a word's evolved contribution
	typedef logic [`CRC_W-1:0] crc24_t;

	// data word and wishbone data bus
	typedef logic [`WORD_W-1:0] word64_t;

	// burst length and words still to come
	typedef logic [`LEN_W-1:0] burst_len_t;

	// earlier terms a beat covers
	// 0 single word burst start, 1 two word burst start, 2 pair mid burst
	typedef logic [1:0] cover_t;

	// burst controller states
	typedef enum logic [1:0] {
		st_idle,
		st_first,
		st_pairs,
		st_drain
	} burst_state_t;

endpackage

`default_nettype wire

// ==== source/ilk_crc_wb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

// wishbone crc24 engine, register slave plus burst datapath
module ilk_crc_wb_top import ilk_crc_pkg::*; (
	input  logic       clk,
	input  logic       arst,
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  logic [1:0] wb_adr,
	input  word64_t    wb_dat_w,
	output word64_t    wb_dat_r,
	output logic       wb_ack
);

	// register slave to controller
	logic       len_we;
	logic       word_we;
	burst_len_t len_val;
	word64_t    word;
	logic       busy;
	logic       burst_done;

	// controller to counter and gather
	logic       load;
	logic       dec;
	logic       hold;
	logic       emit;
	cover_t     beat_cover;
	burst_len_t remaining;
	logic       drain_end;

	// gather to combiner
	logic       beat_valid;
	cover_t     beat_cover_q;
	crc24_t     evo_dat_0;
	crc24_t     evo_dat_n1;
	crc24_t     crc_out;

	wb_crc_regs wb_crc_regs_i (.*);

	crc_burst_fsm crc_burst_fsm_i (.*);

	burst_word_counter burst_word_counter_i (.*);

	beat_pair_gather beat_pair_gather_i (.*);

	crc24_multi_combine crc24_multi_combine_i (
		.valid   (beat_valid),
		.covered (beat_cover_q),
		.*
	);

endmodule

`default_nettype wire

// ==== source/wb_crc_regs.sv ====
`include "ilk_crc_cfg.svh"
`timescale 1ns/10ps
`default_nettype none

// wishbone classic slave, never stalls, ack the cycle after
module wb_crc_regs import ilk_crc_pkg::*; (
	input  logic       clk,
	input  logic       arst,
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  logic [1:0] wb_adr,
	input  word64_t    wb_dat_w,
	output word64_t    wb_dat_r,
	output logic       wb_ack,
	input  logic       busy,
	input  logic       burst_done,
	input  crc24_t     crc_out,
	output logic       len_we,
	output logic       word_we,
	output burst_len_t len_val,
	output word64_t    word
);

	logic    seen;
	logic    wr_seen;
	logic    done;
	word64_t rd_mux;

	// new request, not the tail of one already acked
	assign seen    = wb_cyc && wb_stb && !wb_ack;
	assign wr_seen = seen && wb_we;

	// length only taken between bursts, and only if it fits
	assign len_we  = wr_seen && wb_adr == `REG_LEN && !busy
		&& wb_dat_w <= word64_t'(`MAX_LEN);
	assign word_we = wr_seen && wb_adr == `REG_DATA && busy;
	assign len_val = wb_dat_w[`LEN_W-1:0];
	assign word    = wb_dat_w;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			wb_ack <= 1'b0;
			done   <= 1'b0;
		end else begin
			wb_ack <= seen;
			// set wins, busy is still high on the done pulse
			if (burst_done)
				done <= 1'b1;
			else if (busy)
				done <= 1'b0;
		end
	end

	always_comb begin
		case (wb_adr)
			`REG_STATUS: rd_mux = {{(`WORD_W-2){1'b0}}, done, busy};
			// final xor of the interlaken crc
			`REG_RESULT: rd_mux = {{(`WORD_W-`CRC_W){1'b0}}, ~crc_out};
			default:     rd_mux = '0;
		endcase
	end

	// read data lines up with ack
	always_ff @(posedge clk) begin
		if (seen)
			wb_dat_r <= rd_mux;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+source
source/ilk_crc_pkg.sv
source/crc24_zero_advance.sv
source/crc24_word_fold.sv
source/crc24_multi_combine.sv
source/beat_pair_gather.sv
source/burst_word_counter.sv
source/crc_burst_fsm.sv
source/wb_crc_regs.sv
source/ilk_crc_wb_top.sv
tb/tb_ilk_crc.sv

// ==== tb/tb_ilk_crc.sv ====
`include "ilk_crc_cfg.svh"
`timescale 1ns/10ps
`default_nettype none

// directed tests for the wishbone crc24 engine
module tb_ilk_crc
	import ilk_crc_pkg::*;
();

	typedef word64_t word_q_t[$];

	// ack wait in cycles and done wait in status reads
	localparam int ACK_LIMIT  = 16;
	localparam int DONE_LIMIT = 32;

	logic       clk;
	logic       arst;
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_we;
	logic [1:0] wb_adr;
	word64_t    wb_dat_w;
	word64_t    wb_dat_r;
	logic       wb_ack;

	// galois lfsr state for the random words
	logic [31:0] lfsr;

	ilk_crc_wb_top ilk_crc_wb_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////
	// failure reporting and checks

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_crc(input string name, input crc24_t exp, input crc24_t act);
		if (act !== exp)
			abort_run($sformatf("[ERROR] %s expected %06h actual %06h", name, exp, act));
	endtask

	// bit 1 done, bit 0 busy
	task automatic check_status(input string name, input logic [1:0] exp,
		input logic [1:0] act);
		if (act !== exp)
			abort_run($sformatf("[ERROR] %s status expected %b actual %b", name, exp, act));
	endtask

	//////////////////////////////
	// wishbone master

	// one classic cycle with signals held until ack
	// entered and left 1 ns after a rising edge
	task automatic wb_cycle(input logic we, input logic [1:0] adr, input word64_t dat_w,
		output word64_t dat_r);
		int waited;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat_w;
		waited   = 0;
		// always step one edge since an ack from the last cycle may still be high
		do begin
			@(posedge clk);
			#1;
			waited++;
			if (!wb_ack && waited >= ACK_LIMIT)
				abort_run($sformatf("no wb_ack within %0d cycles at address %0d",
					ACK_LIMIT, adr));
		end while (!wb_ack);
		dat_r  = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input logic [1:0] adr, input word64_t dat);
		word64_t unused_rd;
		wb_cycle(1'b1, adr, dat, unused_rd);
	endtask

	task automatic wb_read(input logic [1:0] adr, output word64_t dat);
		wb_cycle(1'b0, adr, '0, dat);
	endtask

	// poll status until done shows up
	task automatic wait_done(input string name);
		word64_t st;
		int      polls;
		polls = 0;
		do begin
			wb_read(`REG_STATUS, st);
			polls++;
			if (!st[1] && polls >= DONE_LIMIT)
				abort_run($sformatf("%s never set done after %0d status reads", name, polls));
		end while (!st[1]);
	endtask

	//////////////////////////////
	// stimulus and reference

	// taps 32 22 2 1 with one step per bit taken
	function automatic logic lfsr_bit();
		logic out;
		out  = lfsr[0];
		lfsr = (lfsr >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
		return out;
	endfunction

	function automatic word_q_t random_words(input int n);
		word_q_t q;
		word64_t w;
		for (int k = 0; k < n; k++) begin
			w = '0;
			for (int i = 0; i < `WORD_W; i++)
				w = {w[`WORD_W-2:0], lfsr_bit()};
			q.push_back(w);
		end
		return q;
	endfunction

	// bit serial crc24 over the whole burst with msb first and a seed of ones
	function automatic crc24_t ref_crc24(input word_q_t words);
		crc24_t crc;
		logic   fb;
		crc = '1;
		foreach (words[w]) begin
			for (int i = `WORD_W - 1; i >= 0; i--) begin
				fb  = crc[`CRC_W-1] ^ words[w][i];
				crc = {crc[`CRC_W-2:0], 1'b0} ^ (fb ? `CRC_POLY : 24'h0);
			end
		end
		return ~crc;
	endfunction

	task automatic send_words(input word_q_t words);
		foreach (words[i])
			wb_write(`REG_DATA, words[i]);
	endtask

	// done set and busy low before the result is compared with the model
	task automatic finish_burst(input string name, input word_q_t words);
		word64_t rd;
		wait_done(name);
		wb_read(`REG_STATUS, rd);
		check_status(name, 2'b10, rd[1:0]);
		wb_read(`REG_RESULT, rd);
		check_crc(name, ref_crc24(words), rd[`CRC_W-1:0]);
	endtask

	task automatic run_burst(input string name, input word_q_t words);
		wb_write(`REG_LEN, word64_t'(words.size()));
		send_words(words);
		finish_burst(name, words);
	endtask

	//////////////////////////////
	// directed tests

	task automatic reset_values();
		word64_t rd;
		wb_read(`REG_STATUS, rd);
		check_status("reset", 2'b00, rd[1:0]);
		wb_read(`REG_RESULT, rd);
		check_crc("reset", 24'h0, rd[`CRC_W-1:0]);
	endtask

	// cover 0 beat only
	task automatic single_word_burst();
		word_q_t words;
		words.push_back(64'h0123_4567_89ab_cdef);
		run_burst("single", words);
	endtask

	// cover 1 start followed by cover 2 pairs
	task automatic even_bursts();
		word_q_t words;
		words.push_back(64'hdead_beef_0bad_f00d);
		words.push_back(64'h0011_2233_4455_6677);
		run_burst("even_2", words);
		run_burst("even_8", random_words(8));
	endtask

	task automatic odd_bursts();
		run_burst("odd_5", random_words(5));
		run_burst("odd_255", random_words(`MAX_LEN));
	endtask

	task automatic ignored_writes();
		word_q_t words;
		word64_t rd;
		words = random_words(3);
		// data and a zero length are both dropped with no burst open
		wb_write(`REG_DATA, 64'hffff_0000_ffff_0000);
		wb_write(`REG_LEN, 64'd0);
		wb_read(`REG_STATUS, rd);
		check_status("zero_len", 2'b10, rd[1:0]);
		wb_write(`REG_LEN, 64'd3);
		// length rewrite mid burst
		wb_write(`REG_LEN, 64'd5);
		wb_write(`REG_DATA, words[0]);
		wb_write(`REG_DATA, words[1]);
		wb_read(`REG_STATUS, rd);
		check_status("busy_mid_burst", 2'b01, rd[1:0]);
		wb_write(`REG_DATA, words[2]);
		// one word past the length
		wb_write(`REG_DATA, 64'h5555_aaaa_5555_aaaa);
		finish_burst("ignored", words);
		// data after done leaves the result alone
		wb_write(`REG_DATA, 64'h1234_5678_9abc_def0);
		wb_read(`REG_RESULT, rd);
		check_crc("ignored_after_done", ref_crc24(words), rd[`CRC_W-1:0]);
	endtask

	task automatic back_to_back_bursts();
		word_q_t first;
		word_q_t second;
		word64_t rd;
		first  = random_words(4);
		second = random_words(3);
		wb_write(`REG_LEN, word64_t'(first.size()));
		send_words(first);
		wait_done("b2b_first");
		// restart straight away so done must drop
		wb_write(`REG_LEN, word64_t'(second.size()));
		wb_read(`REG_STATUS, rd);
		check_status("b2b_restart", 2'b01, rd[1:0]);
		// no beat issued yet so the first result still stands
		wb_read(`REG_RESULT, rd);
		check_crc("b2b_first", ref_crc24(first), rd[`CRC_W-1:0]);
		send_words(second);
		finish_burst("b2b_second", second);
	endtask

	initial begin
		lfsr     = 32'h3c1c_a1b7;
		arst     = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = 2'd0;
		wb_dat_w = '0;
		repeat (3) @(posedge clk);
		#1;
		arst = 1'b0;
		@(posedge clk);
		#1;
		reset_values();
		single_word_burst();
		even_bursts();
		odd_bursts();
		ignored_writes();
		back_to_back_bursts();
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire
